//--- src.f
src/fpuPkg.sv
src/fpuDecode.sv
src/fpuAdd.sv
src/fpuConvert.sv
src/fpuCompare.sv
src/fpuResult.sv
src/fpuExecute.sv
testbench/fpuExecuteTb.sv

//--- testbench/fpuExecuteTb.sv
/*
 Testbench for the FPU execute unit.
 Inputs change on the falling edge and results are sampled there too.
 Add/sub commands stay on the inputs until HOLD is seen, then exHold is
 raised until the status leaves HOLD.
 Random doubles avoid NaN and infinity, random singles are normal numbers.
*/
`default_nettype none

module fpuExecuteTb;

	logic        clock;
	logic        reset;
	logic [7:0]  opCmd;
	logic [7:0]  opIxt;
	logic [5:0]  regIdRn;
	logic [63:0] regValRs;
	logic [63:0] regValRt;
	logic        regInSrT;
	logic        braFlush;
	logic        exHold;
	wire  [5:0]  regOutId;
	wire  [63:0] regOutVal;
	wire  [63:0] regValGRn;
	wire  [1:0]  regOutOK;
	wire         regOutSrT;

	int          issued;
	int          cycles;
	int          holdSeen;   // HOLD cycles of the last command
	logic [5:0]  issuedRn;
	logic        tExp;       // expected T output

	fpuExecute dut (
		.clock, .reset, .opCmd, .opIxt, .regIdRn, .regValRs, .regValRt,
		.regInSrT, .braFlush, .exHold, .regOutId, .regOutVal, .regValGRn,
		.regOutOK, .regOutSrT
	);

	always #5 clock = ~clock;

	// generous bound per command
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > 40 * issued + 100) begin
			$display("timeout waiting for status");
			$display("TB FAILED");
			$fatal(1);
		end
	end

	task automatic reportMismatch(input string name, input logic [63:0] got,
			input logic [63:0] want);
		$display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
		$display("TB FAILED");
		$fatal(1);
	endtask

	function automatic logic ccPasses(input logic [1:0] cc, input logic t, input logic flush);
		logic pass;
		case (cc)
			fpuPkg::ccAlways: pass = 1'b1;
			fpuPkg::ccTrue:   pass = t;
			fpuPkg::ccFalse:  pass = !t;
			default:          pass = 1'b0;
		endcase
		return pass && !flush;
	endfunction

	function automatic logic [63:0] randomDouble();
		logic [63:0] d;
		d = {$urandom, $urandom};
		if (d[62:52] == 11'h7ff)
			d[62] = 1'b0; // steer away from NaN and infinity
		return d;
	endfunction

	function automatic logic [31:0] randomSingle();
		logic [31:0] s;
		s[31]    = 1'($urandom_range(0, 1));
		s[30:23] = 8'($urandom_range(1, 254));
		s[22:0]  = 23'($urandom);
		return s;
	endfunction

	// real value of a normal single
	function automatic real singleValue(input logic [31:0] s);
		real mag;
		mag = (1.0 + real'(s[22:0]) / 8388608.0) * (2.0 ** (real'(s[30:23]) - 127.0));
		return s[31] ? -mag : mag;
	endfunction

	task automatic driveIdle();
		opCmd    = {fpuPkg::ccAlways, fpuPkg::fpuOpNop};
		opIxt    = 8'd0;
		regIdRn  = 6'd0;
		regValRs = 64'd0;
		regValRt = 64'd0;
		regInSrT = 1'b0;
		braFlush = 1'b0;
	endtask

	// drives one command and returns at the falling edge where its result shows
	task automatic issue(input logic [1:0] cc, input logic [5:0] op, input logic [3:0] ixt,
			input logic [63:0] rs, input logic [63:0] rt, input logic t, input logic flush);
		logic multi;
		multi = (op == fpuPkg::fpuOpFpu3)
			&& ((ixt == fpuPkg::ixtFadd) || (ixt == fpuPkg::ixtFsub));
		@(negedge clock);
		opCmd    = {cc, op};
		opIxt    = {4'd0, ixt};
		regIdRn  = 6'($urandom_range(0, 62));
		issuedRn = regIdRn;
		regValRs = rs;
		regValRt = rt;
		regInSrT = t;
		braFlush = flush;
		issued++;
		@(negedge clock);
		if (!multi)
			driveIdle();
		@(negedge clock);
		holdSeen = 0;
		while (regOutOK == fpuPkg::okHold) begin
			exHold = 1'b1; // inputs stay put
			holdSeen++;
			@(negedge clock);
		end
		exHold = 1'b0;
		driveIdle();
	endtask

	task automatic checkResult(input logic [1:0] expOk, input logic [5:0] expId,
			input logic checkVal, input logic [63:0] expVal, input logic checkGrn,
			input logic [63:0] expGrn, input int expHold);
		assert (holdSeen == expHold)
			else reportMismatch("HOLD cycles", 64'(holdSeen), 64'(expHold));
		assert (regOutOK == expOk)
			else reportMismatch("regOutOK", 64'(regOutOK), 64'(expOk));
		assert (regOutId == expId)
			else reportMismatch("regOutId", 64'(regOutId), 64'(expId));
		assert (!checkVal || (regOutVal == expVal))
			else reportMismatch("regOutVal", regOutVal, expVal);
		assert (!checkGrn || (regValGRn == expGrn))
			else reportMismatch("regValGRn", regValGRn, expGrn);
		assert (regOutSrT == tExp)
			else reportMismatch("regOutSrT", 64'(regOutSrT), 64'(tExp));
	endtask

	task automatic checkIdle();
		@(negedge clock);
		assert (regOutOK == fpuPkg::okReady)
			else reportMismatch("regOutOK", 64'(regOutOK), 64'(fpuPkg::okReady));
		assert (regOutId == fpuPkg::regZero)
			else reportMismatch("regOutId", 64'(regOutId), 64'(fpuPkg::regZero));
		assert (regOutSrT == tExp)
			else reportMismatch("regOutSrT", 64'(regOutSrT), 64'(tExp));
	endtask

	// fmov, fneg or fabs under a condition code
	task automatic unaryCase(input logic [5:0] op, input logic [3:0] ixt, input logic [1:0] cc,
			input logic t, input logic flush);
		logic [63:0] a;
		logic [63:0] expVal;
		a = randomDouble();
		if (op == fpuPkg::fpuOpFpu3)
			expVal = a;
		else if (ixt == fpuPkg::ixtFneg)
			expVal = a ^ {1'b1, 63'd0};
		else
			expVal = a & ~{1'b1, 63'd0};
		issue(cc, op, ixt, a, randomDouble(), t, flush);
		if (ccPasses(cc, t, flush))
			checkResult(fpuPkg::okOk, issuedRn, 1'b1, expVal, 1'b0, 64'd0, 0);
		else
			checkResult(fpuPkg::okReady, fpuPkg::regZero, 1'b0, 64'd0, 1'b0, 64'd0, 0);
		checkIdle();
	endtask

	task automatic addCase(input logic sub);
		int          ia;
		int          ib;
		logic [63:0] expVal;
		ia = int'($urandom_range(0, 2097150)) - 1048575; // below 2^20 in magnitude
		ib = int'($urandom_range(0, 2097150)) - 1048575;
		expVal = sub ? $realtobits(real'(ia) - real'(ib)) : $realtobits(real'(ia) + real'(ib));
		issue(fpuPkg::ccAlways, fpuPkg::fpuOpFpu3, sub ? fpuPkg::ixtFsub : fpuPkg::ixtFadd,
			$realtobits(real'(ia)), $realtobits(real'(ib)), 1'b0, 1'b0);
		checkResult(fpuPkg::okOk, issuedRn, 1'b1, expVal, 1'b0, 64'd0,
			int'(fpuPkg::addHoldCycles));
		checkIdle();
	endtask

	task automatic cmpCase(input logic [63:0] a, input logic [63:0] b, input logic [3:0] ixt);
		issue(fpuPkg::ccAlways, fpuPkg::fpuOpFcmp, ixt, a, b, 1'($urandom_range(0, 1)), 1'b0);
		if (ixt == fpuPkg::ixtCmpEq)
			tExp = ($bitstoreal(a) == $bitstoreal(b)); // real compare has +0 == -0
		else
			tExp = ($bitstoreal(a) > $bitstoreal(b));
		checkResult(fpuPkg::okOk, fpuPkg::regZero, 1'b0, 64'd0, 1'b0, 64'd0, 0);
		checkIdle();
	endtask

	task automatic loadCase();
		logic [31:0] s;
		logic [31:0] other;
		logic        hi;
		s     = randomSingle();
		other = $urandom;
		hi    = 1'($urandom_range(0, 1));
		issue(fpuPkg::ccAlways, fpuPkg::fpuOpFldcx, {hi, 3'b000},
			hi ? {s, other} : {other, s}, 64'd0, 1'b0, 1'b0);
		checkResult(fpuPkg::okOk, issuedRn, 1'b1, $realtobits(singleValue(s)), 1'b0, 64'd0, 0);
		checkIdle();
	endtask

	task automatic storeCase();
		logic [31:0] s;
		s = randomSingle();
		issue(fpuPkg::ccAlways, fpuPkg::fpuOpFstcx, fpuPkg::ixtSingle,
			$realtobits(singleValue(s)), 64'd0, 1'b0, 1'b0);
		checkResult(fpuPkg::okOk, fpuPkg::regZero, 1'b0, 64'd0, 1'b1, {32'd0, s}, 0);
		checkIdle();
	endtask

	initial begin
		logic [63:0] pick;
		void'($urandom(46902));
		clock    = 1'b0;
		reset    = 1'b1;
		exHold   = 1'b0;
		issued   = 0;
		cycles   = 0;
		holdSeen = 0;
		issuedRn = 6'd0;
		tExp     = 1'b0;
		driveIdle();
		repeat (4) @(negedge clock);
		reset = 1'b0;
		checkIdle();
		checkIdle();

		repeat (6) begin
			unaryCase(fpuPkg::fpuOpFpu3, fpuPkg::ixtFmov, fpuPkg::ccAlways, 1'b0, 1'b0);
			unaryCase(fpuPkg::fpuOpFixs, fpuPkg::ixtFneg, fpuPkg::ccAlways, 1'b0, 1'b0);
			unaryCase(fpuPkg::fpuOpFixs, fpuPkg::ixtFabs, fpuPkg::ccAlways, 1'b0, 1'b0);
		end
		repeat (8) begin
			addCase(1'b0);
			addCase(1'b1);
		end

		repeat (8) begin
			cmpCase(randomDouble(), randomDouble(), fpuPkg::ixtCmpEq);
			cmpCase(randomDouble(), randomDouble(), fpuPkg::ixtCmpGt);
		end
		repeat (4) begin
			pick = randomDouble();
			cmpCase(pick, pick, fpuPkg::ixtCmpEq);
			cmpCase(pick, pick, fpuPkg::ixtCmpGt);
		end
		cmpCase(64'd0, {1'b1, 63'd0}, fpuPkg::ixtCmpEq);   // +0 against -0
		cmpCase({1'b1, 63'd0}, 64'd0, fpuPkg::ixtCmpEq);
		cmpCase(64'd0, {1'b1, 63'd0}, fpuPkg::ixtCmpGt);
		cmpCase({1'b1, 63'd0}, 64'd0, fpuPkg::ixtCmpGt);

		repeat (6) begin
			loadCase();
			storeCase();
		end

		// cancelled commands first and then passing conditions
		unaryCase(fpuPkg::fpuOpFixs, fpuPkg::ixtFneg, fpuPkg::ccNever, 1'b1, 1'b0);
		unaryCase(fpuPkg::fpuOpFixs, fpuPkg::ixtFneg, fpuPkg::ccTrue, 1'b0, 1'b0);
		unaryCase(fpuPkg::fpuOpFixs, fpuPkg::ixtFneg, fpuPkg::ccFalse, 1'b1, 1'b0);
		unaryCase(fpuPkg::fpuOpFixs, fpuPkg::ixtFabs, fpuPkg::ccAlways, 1'b0, 1'b1);
		unaryCase(fpuPkg::fpuOpFixs, fpuPkg::ixtFneg, fpuPkg::ccTrue, 1'b1, 1'b0);
		unaryCase(fpuPkg::fpuOpFixs, fpuPkg::ixtFneg, fpuPkg::ccFalse, 1'b0, 1'b0);
		unaryCase(fpuPkg::fpuOpFpu3, fpuPkg::ixtFmov, fpuPkg::ccAlways, 1'b1, 1'b0);

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/fpuExecute.sv
/*
 FPU execute unit, slave to the main execute stage.
 A command sampled at edge N shows on the outputs after edge N+1.
 For add/sub keep the command on the inputs until HOLD is seen, then
 hold exHold high until the status leaves HOLD.
 Outputs are meaningful as a register write only when regOutOK is OK.
*/
`default_nettype none

module fpuExecute (
	input  wire         clock,
	input  wire         reset,
	input  wire  [7:0]  opCmd,
	input  wire  [7:0]  opIxt,
	input  wire  [5:0]  regIdRn,
	input  wire  [63:0] regValRs,
	input  wire  [63:0] regValRt,
	input  wire         regInSrT,
	input  wire         braFlush,
	input  wire         exHold,
	output wire  [5:0]  regOutId,
	output wire  [63:0] regOutVal,
	output wire  [63:0] regValGRn,
	output wire  [1:0]  regOutOK,
	output wire         regOutSrT
);

	fpuPkg::fpuOpReq    req;
	fpuPkg::fpuExResult res;
	logic [63:0]        sum;
	logic [63:0]        singleToDouble;
	logic [31:0]        doubleToSingle;
	logic [63:0]        negated;
	logic [63:0]        absolute;
	logic               srT;

	fpuDecode decode (
		.clock, .reset, .opCmd, .opIxt, .regIdRn, .regValRs, .regValRt,
		.regInSrT, .braFlush, .exHold, .req
	);

	// fsub is the only add/sub extension with bit 0 set
	fpuAdd add (
		.clock, .reset, .valA(req.valRs), .valB(req.valRt), .subtract(req.ixt[0]), .sum
	);

	fpuConvert convert (
		.req, .singleToDouble, .doubleToSingle, .negated, .absolute
	);

	fpuCompare compare (
		.clock, .reset, .req, .exHold, .srT
	);

	fpuResult result (
		.clock, .reset, .exHold, .req, .sum, .singleToDouble, .doubleToSingle,
		.negated, .absolute, .srT, .res
	);

	assign regOutId  = res.outId;
	assign regOutVal = res.outVal;
	assign regValGRn = res.grn;
	assign regOutOK  = res.outOk;
	assign regOutSrT = res.srT;

endmodule

`default_nettype wire

//--- src/fpuResult.sv
/*
 Result select, hold counter and output register.
 Add/sub shows HOLD for addHoldCycles cycles, then OK once. While HOLD
 is shown the register keeps loading even under exHold so the sequence
 can finish. After the OK is delivered the same command reads READY.
 Otherwise the register loads only while exHold is low.
*/
`default_nettype none

module fpuResult (
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   exHold,
	input  wire fpuPkg::fpuOpReq  req,
	input  wire  [63:0]           sum,
	input  wire  [63:0]           singleToDouble,
	input  wire  [31:0]           doubleToSingle,
	input  wire  [63:0]           negated,
	input  wire  [63:0]           absolute,
	input  wire                   srT,
	output fpuPkg::fpuExResult    res
);

	logic [3:0]         holdCyc;
	logic               addBusy;
	logic               outLoad;
	fpuPkg::fpuExResult resD;

	assign addBusy = req.enable && (req.op == fpuPkg::fpuOpFpu3)
		&& ((req.ixt == fpuPkg::ixtFadd) || (req.ixt == fpuPkg::ixtFsub));
	assign outLoad = !exHold || (res.outOk == fpuPkg::okHold);

	// own hold counts through exHold, past addHoldCycles means delivered
	always_ff @(posedge clock) begin
		if (reset || !addBusy)
			holdCyc <= 4'd0;
		else if (holdCyc < fpuPkg::addHoldCycles)
			holdCyc <= holdCyc + 4'd1;
		else if ((holdCyc == fpuPkg::addHoldCycles) && outLoad)
			holdCyc <= holdCyc + 4'd1;
		else if ((holdCyc > fpuPkg::addHoldCycles) && !exHold)
			holdCyc <= 4'd0; // decode takes a fresh command here
	end

	always_comb begin
		resD.outId  = fpuPkg::regZero;
		resD.outVal = 64'd0;
		resD.grn    = 64'd0;
		resD.outOk  = fpuPkg::okReady;
		resD.srT    = srT;
		if (req.enable) begin
			case (req.op)
				fpuPkg::fpuOpFpu3: begin
					if (addBusy && (holdCyc < fpuPkg::addHoldCycles)) begin
						resD.outOk = fpuPkg::okHold;  // no write while counting
					end else if (addBusy && (holdCyc == fpuPkg::addHoldCycles)) begin
						resD.outId  = req.rn;
						resD.outVal = sum;
						resD.grn    = sum;
						resD.outOk  = fpuPkg::okOk;
					end else if (req.ixt == fpuPkg::ixtFmov) begin
						resD.outId  = req.rn;
						resD.outVal = req.valRs;
						resD.grn    = req.valRs;
						resD.outOk  = fpuPkg::okOk;
					end
				end
				fpuPkg::fpuOpFixs: begin
					if ((req.ixt == fpuPkg::ixtFneg) || (req.ixt == fpuPkg::ixtFabs)) begin
						resD.outId  = req.rn;
						resD.outVal = (req.ixt == fpuPkg::ixtFneg) ? negated : absolute;
						resD.grn    = resD.outVal;
						resD.outOk  = fpuPkg::okOk;
					end
				end
				fpuPkg::fpuOpFcmp: begin
					if ((req.ixt == fpuPkg::ixtCmpEq) || (req.ixt == fpuPkg::ixtCmpGt))
						resD.outOk = fpuPkg::okOk;   // T only
				end
				fpuPkg::fpuOpFldcx: begin
					if (req.ixt[2:0] == 3'(fpuPkg::ixtSingle)) begin
						resD.outId  = req.rn;
						resD.outVal = singleToDouble;
						resD.grn    = singleToDouble;
						resD.outOk  = fpuPkg::okOk;
					end
				end
				fpuPkg::fpuOpFstcx: begin
					if (req.ixt == fpuPkg::ixtSingle) begin
						resD.grn   = {32'd0, doubleToSingle}; // GPR side only
						resD.outOk = fpuPkg::okOk;
					end
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			res <= '{outId: fpuPkg::regZero, outVal: 64'd0, grn: 64'd0,
				outOk: fpuPkg::okReady, srT: 1'b0};
		else if (outLoad)
			res <= resD;
	end

endmodule

`default_nettype wire

//--- src/fpuCompare.sv
/*
 Double-precision compare giving the T bit.
 EQ tests Rs == Rt with +0 equal to -0, GT tests Rs > Rt.
 srT is the new T for an enabled FCMP and the held T otherwise.
*/
`default_nettype none

module fpuCompare (
	input  wire                  clock,
	input  wire                  reset,
	input  wire fpuPkg::fpuOpReq req,
	input  wire                  exHold,
	output logic                 srT
);

	logic bothZero;
	logic isEqual;
	logic isGreater;
	logic isCmp;
	logic tHeld;

	always_comb begin
		bothZero = (req.valRs[62:0] == 63'd0) && (req.valRt[62:0] == 63'd0);
		isEqual  = bothZero || (req.valRs == req.valRt);
		if (bothZero)
			isGreater = 1'b0;
		else if (req.valRs[63] != req.valRt[63])
			isGreater = !req.valRs[63];
		else if (req.valRs[63])
			isGreater = req.valRs[62:0] < req.valRt[62:0]; // both negative
		else
			isGreater = req.valRs[62:0] > req.valRt[62:0];

		isCmp = req.enable && (req.op == fpuPkg::fpuOpFcmp);
		srT   = tHeld;
		if (isCmp && (req.ixt == fpuPkg::ixtCmpEq))
			srT = isEqual;
		else if (isCmp && (req.ixt == fpuPkg::ixtCmpGt))
			srT = isGreater;
	end

	always_ff @(posedge clock) begin
		if (reset)
			tHeld <= 1'b0;
		else if (!exHold)
			tHeld <= srT;
	end

endmodule

`default_nettype wire

//--- src/fpuConvert.sv
/*
 Single/double conversions plus negate and absolute value, combinational.
 Denormals convert to signed zero. Double to single truncates the
 mantissa and saturates to infinity on overflow.
 Infinity and NaN exponents pass through with the fraction truncated.
*/
`default_nettype none

module fpuConvert (
	input  wire fpuPkg::fpuOpReq req,
	output logic [63:0]          singleToDouble,
	output logic [31:0]          doubleToSingle,
	output logic [63:0]          negated,
	output logic [63:0]          absolute
);

	logic [31:0] single;     // selected half of Rs
	logic [10:0] widenedExp;
	logic [10:0] dblExp;
	logic [10:0] rebiased;

	always_comb begin
		single     = req.ixt[3] ? req.valRs[63:32] : req.valRs[31:0];
		widenedExp = {3'b000, single[30:23]} + 11'd896; // 1023 - 127
		if (single[30:23] == 8'd0)
			singleToDouble = {single[31], 63'd0};
		else if (single[30:23] == 8'hff)
			singleToDouble = {single[31], 11'h7ff, single[22:0], 29'd0};
		else
			singleToDouble = {single[31], widenedExp, single[22:0], 29'd0};
	end

	always_comb begin
		dblExp   = req.valRs[62:52];
		rebiased = dblExp - 11'd896;
		if (dblExp == 11'h7ff)
			doubleToSingle = {req.valRs[63], 8'hff, req.valRs[51:29]};
		else if (dblExp <= 11'd896)
			doubleToSingle = {req.valRs[63], 31'd0}; // below single range
		else if (dblExp >= 11'd1151)
			doubleToSingle = {req.valRs[63], 8'hff, 23'd0};
		else
			doubleToSingle = {req.valRs[63], rebiased[7:0], req.valRs[51:29]};
	end

	assign negated  = {~req.valRs[63], req.valRs[62:0]};
	assign absolute = {1'b0, req.valRs[62:0]};

endmodule

`default_nettype wire

//--- src/fpuAdd.sv
/*
 Double-precision add/subtract, two register stages.
 Denormal inputs are taken as zero and results below the normal range
 become signed zero. Rounding is truncation toward zero only, so
 overflow gives the largest finite value. NaN inputs are not handled.
 The sum is valid two edges after the operands settle.
*/
`default_nettype none

module fpuAdd (
	input  wire         clock,
	input  wire         reset,
	input  wire  [63:0] valA,
	input  wire  [63:0] valB,
	input  wire         subtract,  // valA - valB
	output logic [63:0] sum
);

	typedef struct packed {
		logic        sign;
		logic [10:0] exp;
		logic        effSub;
		logic [55:0] manBig;    // hidden bit, 52 fraction, guard, round, sticky
		logic [55:0] manSmall;
	} alignStage;

	alignStage   alignD;
	alignStage   alignQ;
	logic        signB;
	logic        swap;
	logic [63:0] bigVal;
	logic [63:0] smallVal;
	logic [55:0] smallExt;
	logic [10:0] expDiff;
	logic [5:0]  alignAmt;
	logic [55:0] shifted;
	logic [56:0] rawSum;
	logic [55:0] normMan;
	logic [5:0]  lz;
	logic [11:0] expNorm;
	logic        underflow;
	logic [63:0] sumD;

	function automatic logic [5:0] leadZeros(input logic [55:0] v);
		logic [5:0] n;
		n = 6'd0;
		for (int i = 0; i < 56; i++) begin
			if (v[i])
				n = 6'(55 - i);
		end
		return n;
	endfunction

	// stage 1 order by magnitude and align the smaller operand
	always_comb begin
		signB    = valB[63] ^ subtract;
		swap     = valB[62:0] > valA[62:0];
		bigVal   = swap ? {signB, valB[62:0]} : valA;
		smallVal = swap ? valA : {signB, valB[62:0]};

		alignD.sign   = bigVal[63];
		alignD.exp    = bigVal[62:52];
		alignD.effSub = bigVal[63] ^ smallVal[63];
		alignD.manBig = (bigVal[62:52] == 11'd0) ? 56'd0 : {1'b1, bigVal[51:0], 3'b000};
		smallExt      = (smallVal[62:52] == 11'd0) ? 56'd0 : {1'b1, smallVal[51:0], 3'b000};

		expDiff  = bigVal[62:52] - smallVal[62:52];
		alignAmt = (expDiff > 11'd56) ? 6'd56 : expDiff[5:0];
		shifted  = smallExt >> alignAmt;
		// lost bits fold into the sticky position
		alignD.manSmall = {shifted[55:1], shifted[0] | ((shifted << alignAmt) != smallExt)};
	end

	always_ff @(posedge clock) begin
		if (reset)
			alignQ <= '0;
		else
			alignQ <= alignD;
	end

	// stage 2 add, normalize, truncate
	always_comb begin
		if (alignQ.effSub)
			rawSum = {1'b0, alignQ.manBig} - {1'b0, alignQ.manSmall};
		else
			rawSum = {1'b0, alignQ.manBig} + {1'b0, alignQ.manSmall};

		lz        = leadZeros(rawSum[55:0]);
		underflow = 1'b0;
		if (rawSum[56]) begin
			normMan = {rawSum[56:2], rawSum[1] | rawSum[0]}; // carry out
			expNorm = {1'b0, alignQ.exp} + 12'd1;
		end else begin
			normMan   = rawSum[55:0] << lz;
			expNorm   = {1'b0, alignQ.exp} - {6'd0, lz};
			underflow = {5'd0, lz} >= alignQ.exp;
		end

		if (alignQ.exp == 11'h7ff)
			sumD = {alignQ.sign, 11'h7ff, 52'd0};
		else if (rawSum == 57'd0)
			sumD = {alignQ.effSub ? 1'b0 : alignQ.sign, 63'd0}; // exact cancel is +0
		else if (underflow)
			sumD = {alignQ.sign, 63'd0};
		else if (expNorm >= 12'h7ff)
			sumD = {alignQ.sign, 11'h7fe, {52{1'b1}}};
		else
			sumD = {alignQ.sign, expNorm[10:0], normMan[54:3]};
	end

	always_ff @(posedge clock) begin
		if (reset)
			sum <= 64'd0;
		else
			sum <= sumD;
	end

endmodule

`default_nettype wire

//--- src/fpuDecode.sv
/*
 Command latch of the FPU execute unit.
 Inputs are sampled on every edge where exHold is low.
 A multi-cycle command must stay on the inputs until its HOLD status
 is seen and exHold is raised, otherwise the next sample replaces it.
 Only extension bits [3:0] are decoded, bits [7:4] are reserved.
*/
`default_nettype none

module fpuDecode (
	input  wire              clock,
	input  wire              reset,
	input  wire  [7:0]       opCmd,    // cc in [7:6], opcode in [5:0]
	input  wire  [7:0]       opIxt,
	input  wire  [5:0]       regIdRn,
	input  wire  [63:0]      regValRs,
	input  wire  [63:0]      regValRt,
	input  wire              regInSrT,
	input  wire              braFlush,
	input  wire              exHold,
	output fpuPkg::fpuOpReq  req
);

	logic        ccPass;
	logic        cmdValid;
	logic        cmdEnable;
	logic [5:0]  cmdOp;
	logic [3:0]  cmdIxt;
	logic [5:0]  cmdRn;
	logic [63:0] cmdRs;
	logic [63:0] cmdRt;

	// condition code against the incoming T bit
	always_comb begin
		case (opCmd[7:6])
			fpuPkg::ccAlways: ccPass = 1'b1;
			fpuPkg::ccNever:  ccPass = 1'b0;
			fpuPkg::ccTrue:   ccPass = regInSrT;
			fpuPkg::ccFalse:  ccPass = !regInSrT;
			default:          ccPass = 1'b0;
		endcase
		cmdValid = ccPass && !braFlush; // flush kills the command in this slot
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			cmdEnable <= 1'b0;
			cmdOp     <= fpuPkg::fpuOpNop;
		end else if (!exHold) begin
			cmdEnable <= cmdValid;
			cmdOp     <= cmdValid ? opCmd[5:0] : fpuPkg::fpuOpNop;
		end
	end

	// operands and ids
	always_ff @(posedge clock) begin
		if (!exHold) begin
			cmdIxt <= opIxt[3:0];
			cmdRn  <= regIdRn;
			cmdRs  <= regValRs;
			cmdRt  <= regValRt;
		end
	end

	assign req = '{
		enable: cmdEnable,
		op:     cmdOp,
		ixt:    cmdIxt,
		rn:     cmdRn,
		valRs:  cmdRs,
		valRt:  cmdRt
	};

endmodule

`default_nettype wire

//--- src/fpuPkg.sv
/*
 Shared codes and records of the FPU execute unit.
 Opcode values are local to this unit and must agree with the main decoder.
 Extension codes occupy the low 4 bits of the 8-bit extension field.
 Status codes follow the main pipeline's execute status encoding.
*/
`default_nettype none

package fpuPkg;

	// opcodes, low 6 bits of the command
	localparam logic [5:0] fpuOpNop   = 6'h00;
	localparam logic [5:0] fpuOpFpu3  = 6'h01;
	localparam logic [5:0] fpuOpFcmp  = 6'h02;
	localparam logic [5:0] fpuOpFldcx = 6'h03;
	localparam logic [5:0] fpuOpFstcx = 6'h04;
	localparam logic [5:0] fpuOpFixs  = 6'h05;

	localparam logic [3:0] ixtFadd   = 4'd0;
	localparam logic [3:0] ixtFsub   = 4'd1;
	localparam logic [3:0] ixtFmov   = 4'd4;
	localparam logic [3:0] ixtFneg   = 4'd0;
	localparam logic [3:0] ixtFabs   = 4'd1;
	localparam logic [3:0] ixtCmpEq  = 4'd0;
	localparam logic [3:0] ixtCmpGt  = 4'd1;
	localparam logic [3:0] ixtSingle = 4'd0; // bit 3 picks the high half on FLDCX

	// condition code, command bits [7:6]
	localparam logic [1:0] ccAlways = 2'd0;
	localparam logic [1:0] ccNever  = 2'd1;
	localparam logic [1:0] ccTrue   = 2'd2;
	localparam logic [1:0] ccFalse  = 2'd3;

	localparam logic [1:0] okReady = 2'd0;
	localparam logic [1:0] okOk    = 2'd1;
	localparam logic [1:0] okHold  = 2'd2;

	localparam logic [3:0] addHoldCycles = 4'd3; // HOLD cycles shown for add/sub
	localparam logic [5:0] regZero       = 6'd63; // no FPR write

	// qualified command as seen by the execute units
	typedef struct packed {
		logic        enable;
		logic [5:0]  op;
		logic [3:0]  ixt;
		logic [5:0]  rn;
		logic [63:0] valRs;
		logic [63:0] valRt;
	} fpuOpReq;

	// registered output of the unit
	typedef struct packed {
		logic [5:0]  outId;
		logic [63:0] outVal;
		logic [63:0] grn;   // value for the GPR side
		logic [1:0]  outOk;
		logic        srT;
	} fpuExResult;

endpackage

`default_nettype wire
